// ==== Bender.yml ====
package:
  name: video_status_mgmt

sources:
  - vsm_pkg.sv
  - status_capture.sv
  - status_fifo.sv
  - status_check.sv
  - pipe_mask_ctrl.sv
  - video_status_mgmt.sv
  - target: test
    files:
      - tb_video_status_mgmt.sv

// ==== pipe_mask_ctrl.sv ====
module pipe_mask_ctrl (
   input  logic                  aggre_clk,
   input  logic                  rst_n,
   input  logic                  end_sch_pulse,            // Round boundary
   input  vsm_pkg::pipe_bitmap_t pipe_concat_en,
   input  vsm_pkg::mask_cfg_t    mask_cfg,
   input  logic                  video_mask_latch_reset,
   input  vsm_pkg::pipe_bitmap_t rd_vld,                   // Buffer heads present
   input  vsm_pkg::pipe_bitmap_t check_ok,                 // Head records good
   output vsm_pkg::pipe_bitmap_t rd_en,                    // Pop pulses
   output vsm_pkg::pipe_bitmap_t clear,                    // Flush pulses
   output logic                  start_sch_pulse,
   output vsm_pkg::pipe_bitmap_t start_sch_pipe_mask_bitmap,
   output vsm_pkg::pipe_bitmap_t start_sch_video_status_pass_bitmap
);

   import vsm_pkg::*;

   pipe_bitmap_t force_mask;     // Config gated by concat
   pipe_bitmap_t auto_mask_en;
   pipe_bitmap_t restart_en;

   pipe_bitmap_t pass_nxt;       // Round result per pipe
   pipe_bitmap_t fail_nxt;
   pipe_bitmap_t latch_q;        // Sticky auto mask
   pipe_bitmap_t latch_set;
   pipe_bitmap_t latch_nxt;
   pipe_bitmap_t mask_nxt;
   pipe_bitmap_t pop_nxt;
   pipe_bitmap_t flush_nxt;

   // ======================================================================
   // Round evaluation
   // ======================================================================

   // Only concatenated pipes take part in masking
   assign force_mask   = pipe_concat_en & mask_cfg.force_mask;
   assign auto_mask_en = pipe_concat_en & mask_cfg.auto_mask_en;
   assign restart_en   = pipe_concat_en & mask_cfg.restart_en;

   assign pass_nxt = pipe_concat_en & rd_vld & check_ok;
   assign fail_nxt = pipe_concat_en & ~pass_nxt;         // Empty buffer fails too

   always_comb begin
      if (video_mask_latch_reset) begin
         latch_set = '0;                                 // Software clears all
      end else begin
         latch_set = latch_q | (auto_mask_en & fail_nxt);
      end
      latch_nxt = latch_set & ~(restart_en & pass_nxt);  // Passing pipe comes back
   end

   assign mask_nxt  = (force_mask | latch_nxt) & pipe_concat_en;
   assign pop_nxt   = pipe_concat_en & rd_vld;           // Consume one record
   assign flush_nxt = latch_nxt & ~latch_q;              // Newly masked pipes

   // ======================================================================
   // Round pulses
   // ======================================================================

   always_ff @(posedge aggre_clk or negedge rst_n) begin
      if (!rst_n) begin
         start_sch_pulse <= 1'b0;
         rd_en           <= '0;
         clear           <= '0;
      end else begin
         start_sch_pulse <= end_sch_pulse;               // One cycle later
         rd_en           <= end_sch_pulse ? pop_nxt : '0;
         clear           <= end_sch_pulse ? flush_nxt : '0;
      end
   end

   // ======================================================================
   // Mask latch and bitmaps
   // ======================================================================

   always_ff @(posedge aggre_clk or negedge rst_n) begin
      if (!rst_n) begin
         latch_q                            <= '0;
         start_sch_pipe_mask_bitmap         <= '0;
         start_sch_video_status_pass_bitmap <= '0;
      end else if (end_sch_pulse) begin
         latch_q                            <= latch_nxt;
         start_sch_pipe_mask_bitmap         <= mask_nxt;   // Held until next round
         start_sch_video_status_pass_bitmap <= pass_nxt;
      end
   end

endmodule

// ==== status_capture.sv ====
module status_capture (
   input  logic                 aggre_clk,
   input  logic                 rst_n,
   input  logic                 header_en,   // Header strobe from the pipe
   input  vsm_pkg::idi_header_t header,
   input  logic                 full,        // Buffer cannot take a record
   output logic                 wr_en,
   output vsm_pkg::status_rec_t wr_rec
);

   import vsm_pkg::*;

   logic        hdr_pend;    // Header taken at last edge, write pending
   idi_header_t hdr_q;       // Captured header fields
   logic        drop_flag;   // Sticky until the next accepted write

   // ======================================================================
   // Header capture
   // ======================================================================

   always_ff @(posedge aggre_clk or negedge rst_n) begin
      if (!rst_n) begin
         hdr_pend <= 1'b0;
      end else begin
         hdr_pend <= header_en;        // One cycle per strobe
      end
   end

   always_ff @(posedge aggre_clk) begin
      if (header_en) begin
         hdr_q <= header;              // Fields for the pending record
      end
   end

   // ======================================================================
   // Overflow tracking
   // ======================================================================

   always_ff @(posedge aggre_clk or negedge rst_n) begin
      if (!rst_n) begin
         drop_flag <= 1'b0;
      end else if (hdr_pend && full) begin
         drop_flag <= 1'b1;            // Header lost to a full buffer
      end else if (wr_en) begin
         drop_flag <= 1'b0;            // Marker went out with this record
      end
   end

   assign wr_en      = hdr_pend & ~full;   // Suppressed while full
   assign wr_rec.ovf = drop_flag;          // Tag first record after a drop
   assign wr_rec.hdr = hdr_q;

endmodule

// ==== status_check.sv ====
module status_check (
   input  vsm_pkg::status_rec_t [vsm_pkg::NUM_PIPES-1:0] rd_rec,   // Head records
   input  vsm_pkg::video_ref_t                           video_ref,
   output vsm_pkg::pipe_bitmap_t                         check_ok
);

   import vsm_pkg::*;

   pipe_bitmap_t dt_ok;   // Datatype matches
   pipe_bitmap_t wc_ok;   // Wordcount matches
   pipe_bitmap_t lc_ok;   // Linecount matches or is ignored

   // ======================================================================
   // Field compares for all pipes in parallel
   // ======================================================================

   always_comb begin
      for (int i = 0; i < NUM_PIPES; i++) begin
         dt_ok[i] = (rd_rec[i].hdr.datatype == video_ref.datatype);
         wc_ok[i] = (rd_rec[i].hdr.wordcount == video_ref.wordcount);
         lc_ok[i] = (rd_rec[i].hdr.linecount == video_ref.linecount) |
                    ~video_ref.lc_chk_en;     // Compare only when enabled
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_PIPES; i++) begin
         // A record after a dropped header never passes
         check_ok[i] = ~rd_rec[i].ovf & dt_ok[i] & wc_ok[i] & lc_ok[i];
      end
   end

endmodule

// ==== status_fifo.sv ====
module status_fifo (
   input  logic                 aggre_clk,
   input  logic                 rst_n,
   input  logic                 wr_en,
   input  vsm_pkg::status_rec_t wr_rec,
   input  logic                 rd_en,    // Pop the head record
   input  logic                 clear,    // Flush all entries
   output logic                 full,
   output logic                 rd_vld,   // Head record present
   output vsm_pkg::status_rec_t rd_rec
);

   import vsm_pkg::*;

   status_rec_t        mem [FIFO_DEPTH];   // Record storage
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;              // Occupancy, 0 to FIFO_DEPTH
   logic               push;
   logic               pop;

   assign push = wr_en & ~full & ~clear;    // Flush wins over a write
   assign pop  = rd_en & rd_vld & ~clear;

   // ======================================================================
   // Storage
   // ======================================================================

   always_ff @(posedge aggre_clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < FIFO_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (push) begin
         mem[wr_ptr] <= wr_rec;
      end
   end

   // ======================================================================
   // Pointers and occupancy
   // ======================================================================

   always_ff @(posedge aggre_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clear) begin
         wr_ptr <= '0;                        // Back to empty
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;          // Wraps at FIFO_DEPTH
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;          // Idle or simultaneous
         endcase
      end
   end

   assign full   = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign rd_vld = (count != '0);
   assign rd_rec = mem[rd_ptr];              // Fall-through head

endmodule

// ==== tb_video_status_mgmt.sv ====
module tb_video_status_mgmt;

   timeunit 1ns;
   timeprecision 100ps;

   import vsm_pkg::*;

   localparam int          CLK_PERIOD   = 100;           // ns
   localparam int          RESET_CYCLES = 16;            // Reset plus idle check
   localparam int          HDR_CYCLES   = 2;             // Per send_header
   localparam int          ROUND_CYCLES = 5;             // Per run_round
   localparam int          NUM_HDRS     = 20;
   localparam int          NUM_ROUNDS   = 15;
   localparam int          NUM_CFGS     = 10;            // One cycle each
   localparam int          STIM_CYCLES  = RESET_CYCLES + NUM_HDRS * HDR_CYCLES +
                                          NUM_ROUNDS * ROUND_CYCLES + NUM_CFGS + 3;
   localparam logic [31:0] SEED         = 32'hd5e3f26c;

   typedef struct packed {
      pipe_bitmap_t pass;    // Expected pass bitmap
      pipe_bitmap_t mask;    // Expected mask bitmap
      pipe_bitmap_t latch;   // Mask latch after the round
   } round_res_t;

   logic                        aggre_clk = 1'b0;
   logic                        rst_n;
   pipe_bitmap_t                idi_header_en;
   idi_header_t [NUM_PIPES-1:0] idi_header;
   pipe_bitmap_t                pipe_concat_en;
   video_ref_t                  video_ref;
   mask_cfg_t                   mask_cfg;
   logic                        video_mask_latch_reset;
   logic                        end_sch_pulse;
   logic                        start_sch_pulse;
   pipe_bitmap_t                start_sch_pipe_mask_bitmap;
   pipe_bitmap_t                start_sch_video_status_pass_bitmap;

   status_rec_t  model_q [NUM_PIPES][$];   // Expected buffer contents
   pipe_bitmap_t model_drop  = '0;         // Expected sticky drop flags
   pipe_bitmap_t model_latch = '0;
   round_res_t   exp_q [$];                // Rounds waiting for compare
   pipe_bitmap_t held_pass   = '0;         // Bitmaps hold between rounds
   pipe_bitmap_t held_mask   = '0;
   logic         end_seen    = 1'b0;
   logic [31:0]  rng;
   int           chk_cnt  = 0;
   int           err_cnt  = 0;
   int           chk_mark = 0;
   int           err_mark = 0;

   always #(CLK_PERIOD / 2) aggre_clk = ~aggre_clk;

   video_status_mgmt i_video_status_mgmt (
      .aggre_clk                          (aggre_clk),
      .rst_n                              (rst_n),
      .idi_header_en                      (idi_header_en),
      .idi_header                         (idi_header),
      .pipe_concat_en                     (pipe_concat_en),
      .video_ref                          (video_ref),
      .mask_cfg                           (mask_cfg),
      .video_mask_latch_reset             (video_mask_latch_reset),
      .end_sch_pulse                      (end_sch_pulse),
      .start_sch_pulse                    (start_sch_pulse),
      .start_sch_pipe_mask_bitmap         (start_sch_pipe_mask_bitmap),
      .start_sch_video_status_pass_bitmap (start_sch_video_status_pass_bitmap)
   );

   // ======================================================================
   // Reference model
   // ======================================================================

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Header equal to the reference values
   function automatic idi_header_t match_header();
      idi_header_t h;
      h.datatype  = video_ref.datatype;
      h.wordcount = video_ref.wordcount;
      h.linecount = video_ref.linecount;
      return h;
   endfunction

   function automatic logic record_ok(input status_rec_t r, input video_ref_t v);
      return !r.ovf && (r.hdr.datatype == v.datatype) && (r.hdr.wordcount == v.wordcount) &&
             ((r.hdr.linecount == v.linecount) || !v.lc_chk_en);
   endfunction

   function automatic round_res_t expect_round(input pipe_bitmap_t vld, input pipe_bitmap_t ok,
                                               input pipe_bitmap_t concat, input mask_cfg_t cfg,
                                               input logic lrst, input pipe_bitmap_t latch_old);
      round_res_t   r;
      pipe_bitmap_t fail;
      r.pass = concat & vld & ok;
      fail   = concat & ~r.pass;                          // Empty buffer counts as fail
      if (lrst) begin
         r.latch = '0;
      end else begin
         r.latch = latch_old | (cfg.auto_mask_en & fail);
      end
      r.latch = r.latch & ~(cfg.restart_en & r.pass);     // Restart after a pass
      r.mask  = (cfg.force_mask | r.latch) & concat;
      return r;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      assert (got === exp) else begin
         $display("FAIL %0.1f ns %s: got %0h, expected %0h", $realtime, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic end_test(input string name);
      $display("%-20s %0d checks, %0d errors", name, chk_cnt - chk_mark, err_cnt - err_mark);
      chk_mark = chk_cnt;
      err_mark = err_cnt;
   endtask

   // ======================================================================
   // Stimulus tasks
   // ======================================================================

   task automatic send_header(input int p, input idi_header_t h);
      pipe_bitmap_t                en;
      idi_header_t [NUM_PIPES-1:0] hv;
      en    = '0;
      en[p] = 1'b1;
      hv    = idi_header;
      hv[p] = h;
      @(posedge aggre_clk);
      idi_header_en <= en;
      idi_header    <= hv;
      @(posedge aggre_clk);
      idi_header_en <= '0;
      if (model_q[p].size() == FIFO_DEPTH) begin
         model_drop[p] = 1'b1;                            // Header lost
      end else begin
         model_q[p].push_back({model_drop[p], h});
         model_drop[p] = 1'b0;
      end
   endtask

   task automatic set_config(input pipe_bitmap_t concat, input mask_cfg_t cfg,
                             input logic lrst, input logic lc_en);
      video_ref_t v;
      v           = video_ref;
      v.lc_chk_en = lc_en;
      @(posedge aggre_clk);
      pipe_concat_en         <= concat;
      mask_cfg               <= cfg;
      video_mask_latch_reset <= lrst;
      video_ref              <= v;
   endtask

   task automatic run_round();
      pipe_bitmap_t vld;
      pipe_bitmap_t ok;
      round_res_t   r;
      logic         seen;
      repeat (3) @(posedge aggre_clk);                    // Headers settled in buffers
      for (int p = 0; p < NUM_PIPES; p++) begin
         vld[p] = (model_q[p].size() != 0);
         ok[p]  = 1'b0;
         if (vld[p]) begin
            ok[p] = record_ok(model_q[p][0], video_ref);
         end
      end
      r = expect_round(vld, ok, pipe_concat_en, mask_cfg, video_mask_latch_reset, model_latch);
      exp_q.push_back(r);
      for (int p = 0; p < NUM_PIPES; p++) begin
         if (pipe_concat_en[p] && vld[p]) begin
            void'(model_q[p].pop_front());
         end
         if (r.latch[p] && !model_latch[p]) begin
            model_q[p].delete();                          // Flush on new mask
         end
      end
      model_latch = r.latch;
      end_sch_pulse <= 1'b1;
      @(posedge aggre_clk);
      end_sch_pulse <= 1'b0;
      seen = 1'b0;
      for (int i = 0; i < 8 && !seen; i++) begin
         @(negedge aggre_clk);
         seen = start_sch_pulse;
      end
      chk_cnt++;
      assert (seen) else begin
         $display("No start_sch_pulse followed end_sch_pulse at %0.1f ns", $realtime);
         err_cnt++;
      end
   endtask

   // ======================================================================
   // Output compare at the falling edge
   // ======================================================================

   always @(negedge aggre_clk) begin
      round_res_t r;
      if (rst_n) begin
         if (end_seen && exp_q.size() != 0) begin
            r         = exp_q.pop_front();
            held_pass = r.pass;
            held_mask = r.mask;
         end
         check_value("start_sch_pulse", start_sch_pulse, end_seen);   // Exactly 1 cycle
         check_value("start_sch_video_status_pass_bitmap",
                     start_sch_video_status_pass_bitmap, held_pass);
         check_value("start_sch_pipe_mask_bitmap", start_sch_pipe_mask_bitmap, held_mask);
         end_seen = end_sch_pulse;
      end
   end

   initial begin
      #(1.5 * STIM_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before the stimulus completed");
      $display("Test failed");
      $finish;
   end

   // ======================================================================
   // Test sequence
   // ======================================================================

   initial begin
      video_ref_t  v;
      idi_header_t h;
      rst_n                  <= 1'b0;
      idi_header_en          <= '0;
      idi_header             <= '0;
      pipe_concat_en         <= '0;
      mask_cfg               <= '0;
      video_mask_latch_reset <= 1'b0;
      end_sch_pulse          <= 1'b0;
      rng         = xorshift32(SEED);
      v.datatype  = 6'h2b;
      v.wordcount = rng[15:0];
      v.linecount = rng[18:16];
      v.lc_chk_en = 1'b1;
      video_ref <= v;
      repeat (10) @(posedge aggre_clk);
      rst_n <= 1'b1;

      repeat (5) @(negedge aggre_clk);                    // Reset values before any round
      check_value("start_sch_pulse", start_sch_pulse, 1'b0);
      check_value("start_sch_pipe_mask_bitmap", start_sch_pipe_mask_bitmap, '0);
      check_value("start_sch_video_status_pass_bitmap", start_sch_video_status_pass_bitmap, '0);
      end_test("reset");

      set_config(4'hf, '0, 1'b0, 1'b1);                   // All pipes with matching headers
      for (int p = 0; p < NUM_PIPES; p++) begin
         send_header(p, match_header());
      end
      run_round();
      check_value("start_sch_video_status_pass_bitmap", start_sch_video_status_pass_bitmap,
                  pipe_concat_en);
      check_value("start_sch_pipe_mask_bitmap", start_sch_pipe_mask_bitmap, '0);
      end_test("matching headers");

      set_config(4'hf, mask_cfg_t'{force_mask: 4'h0, auto_mask_en: 4'h2, restart_en: 4'h0},
                 1'b0, 1'b1);
      rng = xorshift32(rng);
      h = match_header();
      h.wordcount = h.wordcount ^ (rng[15:0] | 16'h0001);   // Wordcount mismatch
      send_header(1, h);
      send_header(1, match_header());                     // Queued then flushed by the mask
      for (int n = 0; n < 3; n++) begin
         run_round();
         check_value("start_sch_pipe_mask_bitmap[1]", start_sch_pipe_mask_bitmap[1], 1'b1);
         check_value("start_sch_video_status_pass_bitmap[1]",
                     start_sch_video_status_pass_bitmap[1], 1'b0);
      end
      end_test("auto mask latching");

      set_config(4'hf, mask_cfg_t'{force_mask: 4'h0, auto_mask_en: 4'h2, restart_en: 4'h2},
                 1'b0, 1'b1);
      send_header(1, match_header());
      run_round();
      check_value("start_sch_pipe_mask_bitmap[1]", start_sch_pipe_mask_bitmap[1], 1'b0);
      set_config(4'hf, mask_cfg_t'{force_mask: 4'h0, auto_mask_en: 4'h6, restart_en: 4'h0},
                 1'b0, 1'b1);
      h = match_header();
      h.datatype = ~h.datatype;
      send_header(1, h);
      send_header(2, h);
      run_round();
      check_value("start_sch_pipe_mask_bitmap", start_sch_pipe_mask_bitmap, 4'h6);
      set_config(4'hf, mask_cfg, 1'b1, 1'b1);             // Latch reset raised
      run_round();
      check_value("start_sch_pipe_mask_bitmap", start_sch_pipe_mask_bitmap, '0);
      set_config(4'hf, mask_cfg, 1'b0, 1'b1);
      end_test("restart and reset");

      set_config(4'h7, mask_cfg_t'{force_mask: 4'h1, auto_mask_en: 4'h0, restart_en: 4'h0},
                 1'b0, 1'b1);
      for (int p = 0; p < NUM_PIPES; p++) begin
         send_header(p, match_header());
      end
      h = match_header();
      h.datatype = ~h.datatype;
      send_header(3, h);                                  // Second record on pipe 3
      run_round();
      check_value("start_sch_pipe_mask_bitmap[0]", start_sch_pipe_mask_bitmap[0], 1'b1);
      check_value("start_sch_pipe_mask_bitmap[3]", start_sch_pipe_mask_bitmap[3], 1'b0);
      check_value("start_sch_video_status_pass_bitmap[3]",
                  start_sch_video_status_pass_bitmap[3], 1'b0);
      set_config(4'h8, '0, 1'b0, 1'b1);
      run_round();                                        // Pipe 3 head never popped
      check_value("start_sch_video_status_pass_bitmap[3]",
                  start_sch_video_status_pass_bitmap[3], 1'b1);
      run_round();
      check_value("start_sch_video_status_pass_bitmap[3]",
                  start_sch_video_status_pass_bitmap[3], 1'b0);
      end_test("force mask and concat");

      set_config(4'h1, '0, 1'b0, 1'b1);
      for (int n = 0; n < 5; n++) begin
         h = match_header();
         if (n == 1 || n == 3) begin
            h.linecount = ~video_ref.linecount;           // Linecount mismatch
         end
         send_header(0, h);                               // Fifth one dropped
      end
      run_round();
      check_value("start_sch_video_status_pass_bitmap[0]",
                  start_sch_video_status_pass_bitmap[0], 1'b1);
      send_header(0, match_header());                     // Carries the overflow mark
      run_round();
      check_value("start_sch_video_status_pass_bitmap[0]",
                  start_sch_video_status_pass_bitmap[0], 1'b0);
      set_config(4'h1, '0, 1'b0, 1'b0);                   // Linecount compare off
      run_round();
      run_round();
      check_value("start_sch_video_status_pass_bitmap[0]",
                  start_sch_video_status_pass_bitmap[0], 1'b1);
      run_round();
      check_value("start_sch_video_status_pass_bitmap[0]",
                  start_sch_video_status_pass_bitmap[0], 1'b0);
      end_test("overflow");

      repeat (3) @(posedge aggre_clk);
      $display("Total: %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== video_status_mgmt.sv ====
module video_status_mgmt (
   input  logic                                          aggre_clk,
   input  logic                                          rst_n,
   input  vsm_pkg::pipe_bitmap_t                         idi_header_en,
   input  vsm_pkg::idi_header_t [vsm_pkg::NUM_PIPES-1:0] idi_header,
   input  vsm_pkg::pipe_bitmap_t                         pipe_concat_en,
   input  vsm_pkg::video_ref_t                           video_ref,
   input  vsm_pkg::mask_cfg_t                            mask_cfg,
   input  logic                                          video_mask_latch_reset,
   input  logic                                          end_sch_pulse,
   output logic                                          start_sch_pulse,
   output vsm_pkg::pipe_bitmap_t                         start_sch_pipe_mask_bitmap,
   output vsm_pkg::pipe_bitmap_t                         start_sch_video_status_pass_bitmap
);

   import vsm_pkg::*;

   // ======================================================================
   // Internal signals
   // ======================================================================

   pipe_bitmap_t                  wr_en;      // Capture to buffer
   status_rec_t [NUM_PIPES-1:0]   wr_rec;
   pipe_bitmap_t                  full;
   pipe_bitmap_t                  rd_vld;     // Buffer heads
   status_rec_t [NUM_PIPES-1:0]   rd_rec;
   pipe_bitmap_t                  rd_en;      // Control to buffers
   pipe_bitmap_t                  clear;
   pipe_bitmap_t                  check_ok;   // Checker to control

   // ======================================================================
   // Per-pipe capture and buffer
   // ======================================================================

   for (genvar i = 0; i < NUM_PIPES; i++) begin : g_pipe
      status_capture u_status_capture (
         .aggre_clk (aggre_clk),
         .rst_n     (rst_n),
         .header_en (idi_header_en[i]),
         .header    (idi_header[i]),
         .full      (full[i]),
         .wr_en     (wr_en[i]),
         .wr_rec    (wr_rec[i])
      );

      status_fifo u_status_fifo (
         .aggre_clk (aggre_clk),
         .rst_n     (rst_n),
         .wr_en     (wr_en[i]),
         .wr_rec    (wr_rec[i]),
         .rd_en     (rd_en[i]),    // Popped once per round
         .clear     (clear[i]),    // Flushed on new mask
         .full      (full[i]),
         .rd_vld    (rd_vld[i]),
         .rd_rec    (rd_rec[i])
      );
   end

   // ======================================================================
   // Status check and round control
   // ======================================================================

   status_check u_status_check (
      .rd_rec    (rd_rec),
      .video_ref (video_ref),
      .check_ok  (check_ok)
   );

   pipe_mask_ctrl u_pipe_mask_ctrl (
      .aggre_clk                          (aggre_clk),
      .rst_n                              (rst_n),
      .end_sch_pulse                      (end_sch_pulse),
      .pipe_concat_en                     (pipe_concat_en),
      .mask_cfg                           (mask_cfg),
      .video_mask_latch_reset             (video_mask_latch_reset),
      .rd_vld                             (rd_vld),
      .check_ok                           (check_ok),
      .rd_en                              (rd_en),
      .clear                              (clear),
      .start_sch_pulse                    (start_sch_pulse),
      .start_sch_pipe_mask_bitmap         (start_sch_pipe_mask_bitmap),
      .start_sch_video_status_pass_bitmap (start_sch_video_status_pass_bitmap)
   );

endmodule

// ==== vlog.f ====
vsm_pkg.sv
status_capture.sv
status_fifo.sv
status_check.sv
pipe_mask_ctrl.sv
video_status_mgmt.sv
tb_video_status_mgmt.sv

// ==== vsm_pkg.sv ====
package vsm_pkg;

   // ======================================================================
   // Sizes
   // ======================================================================

   localparam int NUM_PIPES  = 4;   // Video pipes into the aggregator
   localparam int FIFO_DEPTH = 4;   // Status records per pipe buffer
   localparam int FIFO_AW    = 2;   // Buffer pointer width

   localparam int DT_W = 6;         // Packet datatype
   localparam int WC_W = 16;        // Packet wordcount
   localparam int LC_W = 3;         // Low linecount bits carried in the header

   // ======================================================================
   // Types
   // ======================================================================

   typedef logic [NUM_PIPES-1:0] pipe_bitmap_t;   // One bit per pipe

   // Header fields as seen on one pipe's IDI
   typedef struct packed {
      logic [DT_W-1:0] datatype;
      logic [WC_W-1:0] wordcount;
      logic [LC_W-1:0] linecount;
   } idi_header_t;

   // Queued entry with the header and the lost-header marker
   typedef struct packed {
      logic        ovf;    // A header before this one was dropped
      idi_header_t hdr;
   } status_rec_t;

   // Register values each head record is compared against
   typedef struct packed {
      logic [DT_W-1:0] datatype;
      logic [WC_W-1:0] wordcount;
      logic [LC_W-1:0] linecount;
      logic            lc_chk_en;   // Linecount compare on
   } video_ref_t;

   // Per-pipe mask controls
   typedef struct packed {
      pipe_bitmap_t force_mask;     // Mask regardless of status
      pipe_bitmap_t auto_mask_en;   // Latch mask on a failing round
      pipe_bitmap_t restart_en;     // Unmask again on a passing round
   } mask_cfg_t;

endpackage
